//--- bench/cp0_tb.sv
`include "cp0_defs.svh"

module cp0_tb;
	localparam logic [7:0] F_ADEL = 8'h01, F_ADES = 8'h02, F_SYS = 8'h04, F_BP = 8'h08;
	localparam logic [7:0] F_RI = 8'h10, F_OV = 8'h20, F_TR = 8'h40, F_ERET = 8'h80;
	localparam logic [31:0] PC0 = 32'h8000_1000;

	logic clk, rst_i, valid_i, in_delay_slot_i, we_i, timer_int_o, flush_o;
	logic adel_i, ades_i, syscall_i, break_i, ri_i, ov_i, trap_i, eret_i;
	logic [31:0] pc_i, bad_addr_i, wdata_i, rdata_o, new_pc_o;
	logic [4:0] waddr_i, raddr_i;
	logic [5:0] int_i;

	typedef struct {
		string name;
		logic we, late, rnd, valid, ds, rd, exp_flush;
		logic [4:0] waddr, raddr;
		logic [31:0] wdata, pc, bad;
		logic [7:0] flags;
		logic [5:0] intr;
	} row_t;

	row_t rows[$];
	logic [31:0] lfsr = 32'h40e4_69a6;
	logic [31:0] m_status = `CP0_STATUS_RST, m_cause = '0, m_epc = '0, m_bad = '0, m_cmp = '0;
	logic [5:0] prev_int = '0;

	cp0_top u_cp0_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [31:0] lfsr_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) w = {w[30:0], lfsr_bit()};
		return w;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	function automatic row_t blank_row(input string name, input logic [5:0] intr);
		row_t r;
		r.name = name;
		r.intr = intr;
		{r.we, r.late, r.rnd, r.valid, r.ds, r.rd, r.exp_flush} = '0;
		{r.waddr, r.raddr, r.wdata, r.pc, r.bad, r.flags} = '0;
		return r;
	endfunction

	task automatic add_write(string name, logic [4:0] a, logic [31:0] d, logic rnd, logic [5:0] it);
		row_t r;
		r = blank_row(name, it);
		r.we = 1;
		r.waddr = a;
		r.wdata = d;
		r.rnd = rnd;
		rows.push_back(r);
	endtask

	task automatic add_read(string name, logic [4:0] a, logic [5:0] it);
		row_t r;
		r = blank_row(name, it);
		r.rd = 1;
		r.raddr = a;
		rows.push_back(r);
	endtask

	task automatic add_excp(string name, logic [7:0] f, logic [31:0] pc, logic ds,
			logic [31:0] bad, logic [5:0] it, logic fl);
		row_t r;
		r = blank_row(name, it);
		r.valid = 1;
		r.flags = f;
		r.pc = pc;
		r.ds = ds;
		r.bad = bad;
		r.exp_flush = fl;
		rows.push_back(r);
	endtask

	// mtc0 lands in the same cycle the record is consumed
	task automatic add_excp_late(string name, logic [7:0] f, logic [4:0] a, logic [31:0] d,
			logic rnd);
		row_t r;
		r = blank_row(name, 0);
		r.valid = 1;
		r.flags = f;
		r.pc = PC0;
		r.exp_flush = 1;
		r.we = 1;
		r.late = 1;
		r.waddr = a;
		r.wdata = d;
		r.rnd = rnd;
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		logic [31:0] data, exp_pc, exp_rd;
		logic pend, m_flush;
		int code;
		data = r.rnd ? lfsr_word() : r.wdata;
		pend = m_status[0] & ~m_status[1] & (|({prev_int, m_cause[9:8]} & m_status[15:8]));
		code = -1; // -1 none and -2 eret
		if (r.valid) begin
			if (pend) code = 0;
			else if (r.flags[0]) code = 4;
			else if (r.flags[1]) code = 5;
			else if (r.flags[4]) code = 10;
			else if (r.flags[5]) code = 12;
			else if (r.flags[6]) code = 13;
			else if (r.flags[2]) code = 8;
			else if (r.flags[3]) code = 9;
			else if (r.flags[7]) code = -2;
		end
		if (r.we) begin
			case (r.waddr)
				`CP0_REG_STATUS:  m_status = data;
				`CP0_REG_CAUSE:   {m_cause[23:22], m_cause[9:8]} = {data[23:22], data[9:8]};
				`CP0_REG_EPC:     m_epc = data;
				`CP0_REG_COMPARE: m_cmp = data;
				default: ;
			endcase
		end
		m_flush = (code != -1);
		exp_pc = `CP0_EXC_VECTOR;
		if (code >= 0) begin
			m_epc = r.ds ? r.pc - 32'd4 : r.pc;
			m_cause[31] = r.ds;
			m_cause[6:2] = code[4:0];
			m_status[1] = 1'b1;
			if (code == 4 || code == 5) m_bad = r.bad;
		end else if (code == -2) begin
			m_status[1] = 1'b0;
			exp_pc = m_epc;
		end
		prev_int = r.intr;

		@(posedge clk);
		#2;
		valid_i = r.valid;
		pc_i = r.pc;
		in_delay_slot_i = r.ds;
		bad_addr_i = r.bad;
		{eret_i, trap_i, ov_i, ri_i, break_i, syscall_i, ades_i, adel_i} = r.flags;
		int_i = r.intr;
		raddr_i = r.raddr;
		we_i = r.we & ~r.late;
		waddr_i = r.waddr;
		wdata_i = data;
		@(posedge clk);
		#2;
		valid_i = 0;
		{eret_i, trap_i, ov_i, ri_i, break_i, syscall_i, ades_i, adel_i} = '0;
		we_i = r.we & r.late;
		@(posedge clk);
		#2;
		we_i = 0;
		check({r.name, " flush"}, 32'(r.exp_flush), 32'(flush_o));
		check({r.name, " flush model"}, 32'(m_flush), 32'(flush_o));
		if (m_flush) check({r.name, " new_pc"}, exp_pc, new_pc_o);
		if (r.rd) begin
			case (r.raddr)
				`CP0_REG_STATUS:   exp_rd = m_status;
				`CP0_REG_CAUSE:    exp_rd = {m_cause[31:16], r.intr, m_cause[9:0]};
				`CP0_REG_EPC:      exp_rd = m_epc;
				`CP0_REG_BADVADDR: exp_rd = m_bad;
				`CP0_REG_COMPARE:  exp_rd = m_cmp;
				`CP0_REG_PRID:     exp_rd = `CP0_PRID_RST;
				`CP0_REG_CONFIG:   exp_rd = `CP0_CONFIG_RST;
				default:           exp_rd = '0;
			endcase
			check({r.name, " rdata"}, exp_rd, rdata_o);
		end
	endtask

	task automatic mtc0(input logic [4:0] a, input logic [31:0] d);
		@(posedge clk);
		#2;
		we_i = 1;
		waddr_i = a;
		wdata_i = d;
		@(posedge clk);
		#2;
		we_i = 0;
	endtask

	initial begin
		rst_i = 1;
		valid_i = 0;
		pc_i = '0;
		in_delay_slot_i = 0;
		bad_addr_i = '0;
		{eret_i, trap_i, ov_i, ri_i, break_i, syscall_i, ades_i, adel_i} = '0;
		we_i = 0;
		waddr_i = '0;
		wdata_i = '0;
		raddr_i = `CP0_REG_PRID;
		int_i = '0;

		add_read("prid", `CP0_REG_PRID, 0);
		add_read("config", `CP0_REG_CONFIG, 0);
		add_read("status_rst", `CP0_REG_STATUS, 0);
		add_write("status_wr", `CP0_REG_STATUS, 0, 1, 0);
		add_read("status_rb", `CP0_REG_STATUS, 0);
		add_write("epc_wr", `CP0_REG_EPC, 0, 1, 0);
		add_read("epc_rb", `CP0_REG_EPC, 0);
		add_write("compare_wr", `CP0_REG_COMPARE, 0, 1, 0);
		add_read("compare_rb", `CP0_REG_COMPARE, 0);
		add_write("cause_wr", `CP0_REG_CAUSE, 0, 1, 6'h15);
		add_read("cause_rb", `CP0_REG_CAUSE, 6'h15);
		add_write("status_clr", `CP0_REG_STATUS, 32'h0, 0, 0);
		add_excp("adel", F_ADEL, 32'h8000_0100, 0, 32'h1234_5671, 0, 1);
		add_read("adel_cause", `CP0_REG_CAUSE, 0);
		add_read("adel_status", `CP0_REG_STATUS, 0);
		add_read("adel_epc", `CP0_REG_EPC, 0);
		add_read("adel_bad", `CP0_REG_BADVADDR, 0);
		add_excp("ades_bd", F_ADES, 32'h8000_0204, 1, 32'h0000_4003, 0, 1);
		add_read("ades_epc", `CP0_REG_EPC, 0);
		add_read("ades_cause", `CP0_REG_CAUSE, 0);
		add_read("ades_bad", `CP0_REG_BADVADDR, 0);
		add_excp("sys", F_SYS, 32'h8000_0300, 0, 32'hdead_0001, 0, 1);
		add_read("sys_cause", `CP0_REG_CAUSE, 0);
		add_excp("bp_bd", F_BP, 32'h8000_0408, 1, 0, 0, 1);
		add_read("bp_cause", `CP0_REG_CAUSE, 0);
		add_read("bp_epc", `CP0_REG_EPC, 0);
		add_excp("ri", F_RI, 32'h8000_0500, 0, 0, 0, 1);
		add_read("ri_cause", `CP0_REG_CAUSE, 0);
		add_excp("ov", F_OV, 32'h8000_0600, 0, 0, 0, 1);
		add_read("ov_cause", `CP0_REG_CAUSE, 0);
		add_excp("tr", F_TR, 32'h8000_0700, 0, 32'hdead_0002, 0, 1);
		add_read("tr_cause", `CP0_REG_CAUSE, 0);
		add_read("tr_bad_kept", `CP0_REG_BADVADDR, 0);
		add_excp("prio_ri", F_SYS | F_RI | F_OV, PC0, 0, 0, 0, 1);
		add_read("prio_ri_cause", `CP0_REG_CAUSE, 0);
		add_excp("prio_adel", F_ADEL | F_ADES | F_TR | F_ERET, PC0, 0, 32'h0bad_0007, 0, 1);
		add_read("prio_adel_bad", `CP0_REG_BADVADDR, 0);
		add_excp("eret", F_ERET, PC0, 0, 0, 0, 1);
		add_read("eret_status", `CP0_REG_STATUS, 0);
		add_excp_late("eret_fwd", F_ERET, `CP0_REG_EPC, 0, 1);
		add_read("eret_fwd_epc", `CP0_REG_EPC, 0);
		add_excp_late("sys_vs_mtc0", F_SYS, `CP0_REG_STATUS, 32'h0, 0);
		add_read("sys_vs_mtc0_st", `CP0_REG_STATUS, 0);
		add_excp("eret2", F_ERET, PC0, 0, 0, 0, 1);
		add_write("int_en", `CP0_REG_STATUS, 32'h0000_0401, 0, 0);
		add_read("int_ip", `CP0_REG_CAUSE, 6'h01);
		add_excp("int_taken", 8'h00, 32'h8000_0800, 0, 0, 6'h01, 1);
		add_read("int_cause", `CP0_REG_CAUSE, 6'h01);
		add_excp("int_exl", 8'h00, PC0, 0, 0, 6'h01, 0);
		add_excp("eret_int", F_ERET, PC0, 0, 0, 6'h00, 1);
		add_excp("int_gone", 8'h00, PC0, 0, 0, 6'h00, 0);
		add_read("int_ip3", `CP0_REG_CAUSE, 6'h02);
		add_excp("int_im_masked", 8'h00, PC0, 0, 0, 6'h02, 0);
		add_write("int_ie_off", `CP0_REG_STATUS, 32'h0000_0400, 0, 6'h01);
		add_excp("int_masked", 8'h00, PC0, 0, 0, 6'h01, 0);

		#5 check("rdata in reset", 32'h0, rdata_o);
		repeat (10) @(posedge clk);
		#2 rst_i = 0;
		check("flush after reset", 32'h0, 32'(flush_o));
		check("timer after reset", 32'h0, 32'(timer_int_o));

		foreach (rows[i]) run_row(rows[i]);

		// count/compare timer
		int_i = '0;
		mtc0(`CP0_REG_COMPARE, 32'd40);
		mtc0(`CP0_REG_COUNT, 32'd0);
		for (int k = 0; k < 200 && !timer_int_o; k++) begin
			@(posedge clk);
			#2;
		end
		if (!timer_int_o) begin
			$display("timeout waiting for the timer interrupt");
			$display("TEST FAILED");
			$fatal(1);
		end
		@(posedge clk);
		#2 raddr_i = `CP0_REG_CAUSE;
		#1 check("timer ip7", 32'h1, 32'(rdata_o[15]));
		mtc0(`CP0_REG_COMPARE, 32'd0);
		check("timer ack", 32'h0, 32'(timer_int_o));

		$display("TEST PASSED");
		$finish;
	end

	initial begin
		#200000;
		$display("simulation ran too long");
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

//--- hw/cp0_pkg.sv
package cp0_pkg;

	// exception record out of the detect stage
	typedef enum logic [3:0] {
		EXC_NONE,
		EXC_INT,
		EXC_ADEL,
		EXC_ADES,
		EXC_SYS,
		EXC_BP,
		EXC_RI,
		EXC_OV,
		EXC_TR,
		EXC_ERET
	} excp_e;

	// Cause.ExcCode field values
	typedef enum logic [4:0] {
		INT  = 5'd0,
		ADEL = 5'd4,
		ADES = 5'd5,
		SYS  = 5'd8,
		BP   = 5'd9,
		RI   = 5'd10,
		OV   = 5'd12,
		TR   = 5'd13
	} excode_e;

endpackage

//--- hw/cp0_regs.sv
`include "cp0_defs.svh"

module cp0_regs (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                we_i,
	input  logic [4:0]          waddr_i,
	input  logic [`CP0_DW-1:0]  wdata_i,
	input  logic [4:0]          raddr_i,
	input  logic [5:0]          int_i,
	input  cp0_pkg::excp_e      excp_i,
	input  logic [`CP0_DW-1:0]  pc_i,
	input  logic                bd_i,
	input  logic [`CP0_DW-1:0]  bad_addr_i,
	output logic [`CP0_DW-1:0]  rdata_o,
	output logic [`CP0_DW-1:0]  status_o,
	output logic [`CP0_DW-1:0]  cause_o,
	output logic [`CP0_DW-1:0]  epc_o,
	output logic                timer_int_o
);

	logic [`CP0_DW-1:0] count_q;
	logic [`CP0_DW-1:0] compare_q;
	logic [`CP0_DW-1:0] status_q;
	logic [`CP0_DW-1:0] cause_q;
	logic [`CP0_DW-1:0] epc_q;
	logic [`CP0_DW-1:0] badvaddr_q;
	logic               timer_int_q;
	logic               take_excp;
	logic               addr_excp;

	function automatic cp0_pkg::excode_e excode_of(cp0_pkg::excp_e e);
		case (e)
			cp0_pkg::EXC_ADEL: return cp0_pkg::ADEL;
			cp0_pkg::EXC_ADES: return cp0_pkg::ADES;
			cp0_pkg::EXC_SYS:  return cp0_pkg::SYS;
			cp0_pkg::EXC_BP:   return cp0_pkg::BP;
			cp0_pkg::EXC_RI:   return cp0_pkg::RI;
			cp0_pkg::EXC_OV:   return cp0_pkg::OV;
			cp0_pkg::EXC_TR:   return cp0_pkg::TR;
			default:           return cp0_pkg::INT;
		endcase
	endfunction

	assign take_excp = (excp_i != cp0_pkg::EXC_NONE) && (excp_i != cp0_pkg::EXC_ERET);
	assign addr_excp = (excp_i == cp0_pkg::EXC_ADEL) || (excp_i == cp0_pkg::EXC_ADES);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			count_q     <= '0;
			compare_q   <= '0;
			status_q    <= `CP0_STATUS_RST;
			cause_q     <= '0;
			epc_q       <= '0;
			badvaddr_q  <= '0;
			timer_int_q <= 1'b0;
		end else begin
			count_q         <= count_q + 1'b1;
			cause_q[15:10]  <= {int_i[5] | timer_int_q, int_i[4:0]}; // timer shares IP7
			if (compare_q != '0 && count_q == compare_q)
				timer_int_q <= 1'b1;

			// mtc0
			if (we_i) begin
				case (waddr_i)
					`CP0_REG_COUNT:   count_q <= wdata_i;
					`CP0_REG_COMPARE: begin
						compare_q   <= wdata_i;
						timer_int_q <= 1'b0; // ack timer
					end
					`CP0_REG_STATUS:  status_q <= wdata_i;
					`CP0_REG_CAUSE: begin
						cause_q[9:8]   <= wdata_i[9:8]; // sw interrupts
						cause_q[23:22] <= wdata_i[23:22];
					end
					`CP0_REG_EPC:     epc_q <= wdata_i;
					default: ;
				endcase
			end

			// exception state, placed after mtc0 so it overrides
			if (take_excp) begin
				epc_q        <= bd_i ? pc_i - 32'd4 : pc_i;
				cause_q[31]  <= bd_i;
				cause_q[6:2] <= excode_of(excp_i);
				status_q[1]  <= 1'b1; // EXL
				if (addr_excp)
					badvaddr_q <= bad_addr_i;
			end else if (excp_i == cp0_pkg::EXC_ERET) begin
				status_q[1] <= 1'b0;
			end
		end
	end

	// mfc0
	always_comb begin
		if (rst_i) begin
			rdata_o = '0;
		end else begin
			case (raddr_i)
				`CP0_REG_COUNT:    rdata_o = count_q;
				`CP0_REG_COMPARE:  rdata_o = compare_q;
				`CP0_REG_STATUS:   rdata_o = status_q;
				`CP0_REG_CAUSE:    rdata_o = cause_q;
				`CP0_REG_EPC:      rdata_o = epc_q;
				`CP0_REG_BADVADDR: rdata_o = badvaddr_q;
				`CP0_REG_PRID:     rdata_o = `CP0_PRID_RST;
				`CP0_REG_CONFIG:   rdata_o = `CP0_CONFIG_RST;
				default:           rdata_o = '0;
			endcase
		end
	end

	assign status_o    = status_q;
	assign cause_o     = cause_q;
	assign epc_o       = epc_q;
	assign timer_int_o = timer_int_q;

	// handler must start with EXL set whatever mtc0 did that cycle
	a_exl_on_entry: assert property (@(posedge clk) disable iff (rst_i)
		take_excp |=> status_o[1]);

endmodule

//--- hw/cp0_top.sv
`include "cp0_defs.svh"

module cp0_top (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                valid_i,
	input  logic [`CP0_DW-1:0]  pc_i,
	input  logic                in_delay_slot_i,
	input  logic [`CP0_DW-1:0]  bad_addr_i,
	input  logic                adel_i,
	input  logic                ades_i,
	input  logic                syscall_i,
	input  logic                break_i,
	input  logic                ri_i,
	input  logic                ov_i,
	input  logic                trap_i,
	input  logic                eret_i,
	input  logic                we_i,
	input  logic [4:0]          waddr_i,
	input  logic [`CP0_DW-1:0]  wdata_i,
	input  logic [4:0]          raddr_i,
	input  logic [5:0]          int_i,
	output logic [`CP0_DW-1:0]  rdata_o,
	output logic                timer_int_o,
	output logic                flush_o,
	output logic [`CP0_DW-1:0]  new_pc_o
);

	cp0_pkg::excp_e     s1_excp;
	logic [`CP0_DW-1:0] s1_pc;
	logic               s1_bd;
	logic [`CP0_DW-1:0] s1_bad_addr;
	logic [`CP0_DW-1:0] status;
	logic [`CP0_DW-1:0] cause;
	logic [`CP0_DW-1:0] epc;

	excp_detect u_detect (
		.clk(clk), .rst_i(rst_i), .valid_i(valid_i), .pc_i(pc_i),
		.in_delay_slot_i(in_delay_slot_i), .bad_addr_i(bad_addr_i),
		.adel_i(adel_i), .ades_i(ades_i), .syscall_i(syscall_i), .break_i(break_i),
		.ri_i(ri_i), .ov_i(ov_i), .trap_i(trap_i), .eret_i(eret_i),
		.status_i(status), .cause_i(cause),
		.excp_o(s1_excp), .pc_o(s1_pc), .bd_o(s1_bd), .bad_addr_o(s1_bad_addr)
	);

	cp0_regs u_regs (
		.clk(clk), .rst_i(rst_i), .we_i(we_i), .waddr_i(waddr_i), .wdata_i(wdata_i),
		.raddr_i(raddr_i), .int_i(int_i), .excp_i(s1_excp), .pc_i(s1_pc),
		.bd_i(s1_bd), .bad_addr_i(s1_bad_addr), .rdata_o(rdata_o),
		.status_o(status), .cause_o(cause), .epc_o(epc), .timer_int_o(timer_int_o)
	);

	excp_redirect u_redirect (
		.clk(clk), .rst_i(rst_i), .excp_i(s1_excp), .epc_i(epc),
		.we_i(we_i), .waddr_i(waddr_i), .wdata_i(wdata_i),
		.flush_o(flush_o), .new_pc_o(new_pc_o)
	);

endmodule

//--- hw/excp_detect.sv
`include "cp0_defs.svh"

module excp_detect (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                valid_i,
	input  logic [`CP0_DW-1:0]  pc_i,
	input  logic                in_delay_slot_i,
	input  logic [`CP0_DW-1:0]  bad_addr_i,
	input  logic                adel_i,
	input  logic                ades_i,
	input  logic                syscall_i,
	input  logic                break_i,
	input  logic                ri_i,
	input  logic                ov_i,
	input  logic                trap_i,
	input  logic                eret_i,
	input  logic [`CP0_DW-1:0]  status_i,
	input  logic [`CP0_DW-1:0]  cause_i,
	output cp0_pkg::excp_e      excp_o,
	output logic [`CP0_DW-1:0]  pc_o,
	output logic                bd_o,
	output logic [`CP0_DW-1:0]  bad_addr_o
);

	logic           int_pending;
	cp0_pkg::excp_e excp_d;

	// IE set, EXL clear, some unmasked IP
	assign int_pending = status_i[0] & ~status_i[1] & (|(cause_i[15:8] & status_i[15:8]));

	always_comb begin
		excp_d = cp0_pkg::EXC_NONE;
		if (valid_i) begin
			if (int_pending)    excp_d = cp0_pkg::EXC_INT;
			else if (adel_i)    excp_d = cp0_pkg::EXC_ADEL;
			else if (ades_i)    excp_d = cp0_pkg::EXC_ADES;
			else if (ri_i)      excp_d = cp0_pkg::EXC_RI;
			else if (ov_i)      excp_d = cp0_pkg::EXC_OV;
			else if (trap_i)    excp_d = cp0_pkg::EXC_TR;
			else if (syscall_i) excp_d = cp0_pkg::EXC_SYS;
			else if (break_i)   excp_d = cp0_pkg::EXC_BP;
			else if (eret_i)    excp_d = cp0_pkg::EXC_ERET;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			excp_o <= cp0_pkg::EXC_NONE;
		end else begin
			excp_o <= excp_d;
		end
	end

	always_ff @(posedge clk) begin
		pc_o       <= pc_i; // context rides along, qualified by excp_o
		bd_o       <= in_delay_slot_i;
		bad_addr_o <= bad_addr_i;
	end

	a_idle_no_excp: assert property (@(posedge clk) disable iff (rst_i)
		!valid_i |=> excp_o == cp0_pkg::EXC_NONE);

endmodule

//--- hw/excp_redirect.sv
`include "cp0_defs.svh"

module excp_redirect (
	input  logic                clk,
	input  logic                rst_i,
	input  cp0_pkg::excp_e      excp_i,
	input  logic [`CP0_DW-1:0]  epc_i,
	input  logic                we_i,
	input  logic [4:0]          waddr_i,
	input  logic [`CP0_DW-1:0]  wdata_i,
	output logic                flush_o,
	output logic [`CP0_DW-1:0]  new_pc_o
);

	logic               epc_fwd;
	logic [`CP0_DW-1:0] eret_pc;
	logic [`CP0_DW-1:0] target;

	// mtc0 epc lands at the same edge, so bypass it
	assign epc_fwd = we_i && (waddr_i == `CP0_REG_EPC);
	assign eret_pc = epc_fwd ? wdata_i : epc_i;
	assign target  = (excp_i == cp0_pkg::EXC_ERET) ? eret_pc : `CP0_EXC_VECTOR;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			flush_o <= 1'b0;
		end else begin
			flush_o <= excp_i != cp0_pkg::EXC_NONE; // one pulse per record
		end
	end

	always_ff @(posedge clk) begin
		new_pc_o <= target; // only meaningful with flush_o
	end

	a_flush_pulse: assert property (@(posedge clk) disable iff (rst_i)
		(flush_o && $past(flush_o)) |->
			($past(excp_i, 1) != cp0_pkg::EXC_NONE && $past(excp_i, 2) != cp0_pkg::EXC_NONE));

endmodule

//--- include/cp0_defs.svh
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// datapath width
`define CP0_DW 32

// cp0 register numbers (sel 0)
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// reset values
`define CP0_STATUS_RST 32'h0040_0000 // BEV set
`define CP0_CONFIG_RST 32'h0000_8000 // bit 15 set
`define CP0_PRID_RST   32'h004c_0102

// general exception entry
`define CP0_EXC_VECTOR 32'hbfc0_0380

`endif

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cp0_tb -f sim.f -o Vcp0_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vcp0_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- sim.f
+incdir+include
hw/cp0_pkg.sv
hw/excp_detect.sv
hw/cp0_regs.sv
hw/excp_redirect.sv
hw/cp0_top.sv
bench/cp0_tb.sv
